// File: all.f
+incdir+tests
verilog/mmu_pkg.sv
verilog/pebble_bounds.sv
verilog/tlb_direct.sv
verilog/xlat_combine.sv
verilog/mmu_top.sv
tests/tb_mmu.sv

// File: run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mmu -f all.f

# The simulation status is ignored; the pass line decides
out=$(./obj_dir/Vtb_mmu 2>&1) || true
echo "$out"

echo "$out" | grep -qx "Result: PASSED"
echo "simulation passed"

// File: tests/tb_mmu_cases.svh
// Included inside tb_mmu after mmu_pkg is imported and the seed variable is declared

localparam int NUM_CASES = 11;

typedef struct packed {
	mmu_wr_t             wr0;          // Optional writes, en low means none
	mmu_wr_t             wr1;
	logic                paging_en;
	logic                pebble_en;
	logic [REGSET_W-1:0] regset;
	xlat_req_t           req;
	logic [3:0]          hold;         // Extra cycles req stays high after ack
	logic [VADR_W-1:0]   exp_padr;     // Only meaningful without a fault
	fault_e              exp_fault;
} case_t;

case_t cases [NUM_CASES];
string case_name [NUM_CASES];
int    fill_idx;

// Valid TLB entry write
function automatic mmu_wr_t tlb_write(input logic [TLB_IDX_W-1:0] idx,
	input logic [TAG_W-1:0] tag, input logic [ASID_W-1:0] asid, input logic wr_ok,
	input logic [CPL_W-1:0] pl, input logic [PPN_W-1:0] ppn);
	mmu_wr_t    w;
	tlb_entry_t e;
	e.tag          = tag;
	e.asid         = asid;
	e.pte.valid    = 1'b1;
	e.pte.writable = wr_ok;
	e.pte.pl       = pl;
	e.pte.ppn      = ppn;
	w.en           = 1'b1;
	w.target       = WR_TLB;
	w.index        = idx;
	w.data         = e;
	return w;
endfunction

// Segment limit write, index is {regset, selector}
function automatic mmu_wr_t bound_write(input logic [REGSET_W-1:0] rs,
	input logic [SEG_SEL_W-1:0] sel, input logic [LIMIT_W-1:0] limit);
	mmu_wr_t w;
	w                    = '0;
	w.en                 = 1'b1;
	w.target             = WR_BOUND;
	w.index              = {rs, sel};
	w.data[LIMIT_W-1:0]  = limit;
	return w;
endfunction

function automatic xlat_req_t make_req(input logic [VADR_W-1:0] vadr,
	input logic [ASID_W-1:0] asid, input logic [CPL_W-1:0] cpl, input logic we);
	xlat_req_t r;
	r.vadr = vadr;
	r.asid = asid;
	r.cpl  = cpl;
	r.we   = we;
	return r;
endfunction

task automatic add_case(input string name, input mmu_wr_t w0, input mmu_wr_t w1,
	input logic pg, input logic pb, input logic [REGSET_W-1:0] rs, input xlat_req_t rq,
	input logic [3:0] hold, input logic [VADR_W-1:0] padr, input fault_e flt);
	case_name[fill_idx]       = name;
	cases[fill_idx].wr0       = w0;
	cases[fill_idx].wr1       = w1;
	cases[fill_idx].paging_en = pg;
	cases[fill_idx].pebble_en = pb;
	cases[fill_idx].regset    = rs;
	cases[fill_idx].req       = rq;
	cases[fill_idx].hold      = hold;
	cases[fill_idx].exp_padr  = padr;
	cases[fill_idx].exp_fault = flt;
	fill_idx++;
endtask

// ==================================================
// Case table
// ==================================================
task automatic fill_cases();
	logic [31:0]           rnd;
	logic [PAGE_OFS_W-1:0] ofs [4];
	logic [TAG_W-1:0]      seg_tag;
	mmu_wr_t               none;
	mmu_wr_t               hit_wr;
	mmu_wr_t               ro_wr;
	xlat_req_t             seg_rq;
	fill_idx = 0;
	none     = '0;
	seg_tag  = {4'h6, 9'h000};                 // Segment 6, bits above the index clear
	for (int k = 0; k < 4; k++) begin
		rnd    = $random(seed);
		ofs[k] = rnd[PAGE_OFS_W-1:0];
	end
	rnd    = $random(seed);                    // Whole address for pass-through
	hit_wr = tlb_write(6'd5, 13'h0a3, 8'h21, 1'b1, 2'd3, 19'h45678);
	ro_wr  = tlb_write(6'd12, 13'h155, 8'h05, 1'b0, 2'd1, 19'h70001);   // Read-only, pl 1
	seg_rq = make_req({seg_tag, 6'd9, ofs[2]}, 8'h21, 2'd0, 1'b0);      // Page 9 of segment

	add_case("passthru", none, none, 1'b0, 1'b0, 2'd0,
		make_req(rnd, 8'h00, 2'd3, 1'b1), 4'd0, rnd, FLT_NONE);
	add_case("tlb_hit", hit_wr, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h0a3, 6'd5, ofs[0]}, 8'h21, 2'd0, 1'b0), 4'd0,
		{19'h45678, ofs[0]}, FLT_NONE);
	add_case("asid_miss", none, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h0a3, 6'd5, ofs[0]}, 8'h22, 2'd0, 1'b0), 4'd0, '0, FLT_MISS);
	add_case("never_written", none, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h1f0, 6'd40, ofs[1]}, 8'h21, 2'd0, 1'b0), 4'd0, '0, FLT_MISS);
	// Limit 3 in set 1, segment 6; page 9 is over it
	add_case("bound_exc", bound_write(2'd1, 4'h6, 15'd3),
		tlb_write(6'd9, seg_tag, 8'h21, 1'b1, 2'd3, 19'h12345),
		1'b1, 1'b1, 2'd1, seg_rq, 4'd0, '0, FLT_BOUND);
	add_case("bound_off", none, none, 1'b1, 1'b0, 2'd1, seg_rq, 4'd0,
		{19'h12345, ofs[2]}, FLT_NONE);
	add_case("bound_edge", tlb_write(6'd3, seg_tag, 8'h21, 1'b1, 2'd3, 19'h0abcd), none,
		1'b1, 1'b1, 2'd1, make_req({seg_tag, 6'd3, ofs[3]}, 8'h21, 2'd0, 1'b0), 4'd0,
		{19'h0abcd, ofs[3]}, FLT_NONE);
	add_case("priv", ro_wr, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h155, 6'd12, ofs[1]}, 8'h05, 2'd2, 1'b0), 4'd0, '0, FLT_PRIV);
	add_case("ro_write", none, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h155, 6'd12, ofs[1]}, 8'h05, 2'd1, 1'b1), 4'd0, '0, FLT_WRITE);
	add_case("ro_read", none, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h155, 6'd12, ofs[1]}, 8'h05, 2'd1, 1'b0), 4'd0,
		{19'h70001, ofs[1]}, FLT_NONE);
	add_case("hold_ack", none, none, 1'b1, 1'b0, 2'd0,
		make_req({13'h0a3, 6'd5, ofs[0]}, 8'h21, 2'd0, 1'b1), 4'd5,
		{19'h45678, ofs[0]}, FLT_NONE);
endtask

// File: tests/tb_mmu.sv
// Single requester with writes only between handshakes; padr is compared only when no fault is expected
`timescale 1ns/1ns
`default_nettype none

module tb_mmu import mmu_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 8;
	localparam int DRV        = 1;             // Input drive delay after the edge
	localparam int ACK_LAT    = 2;             // Edge into ST_LOOK and then the edge that registers resp
	localparam int ACK_WAIT   = 16;            // Give up on a handshake after this

	logic       clk = 1'b0;
	logic       rst;
	logic       req;
	xlat_req_t  xreq;
	logic       paging_en;
	logic       pebble_en;
	logic [REGSET_W-1:0] regset;
	mmu_wr_t    wr;
	logic       ack;
	xlat_resp_t resp;

	integer seed;
	int     errors;
	int     n_pass;

	`include "tb_mmu_cases.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	mmu_top mmu_top_i (
		.clk         (clk),
		.rst         (rst),
		.req_i       (req),
		.xlat_req_i  (xreq),
		.paging_en_i (paging_en),
		.pebble_en_i (pebble_en),
		.regset_i    (regset),
		.wr_i        (wr),
		.ack_o       (ack),
		.resp_o      (resp)
	);

	function automatic string fault_name(input fault_e f);
		case (f)
			FLT_NONE:  return "none";
			FLT_BOUND: return "bound";
			FLT_MISS:  return "miss";
			FLT_PRIV:  return "priv";
			FLT_WRITE: return "write";
			default:   return "unknown";
		endcase
	endfunction

	// One-cycle strobe that takes effect at the next edge
	task automatic apply_write(input mmu_wr_t w);
		if (w.en) begin
			wr = w;
			@(posedge clk);
			#DRV;
			wr = '0;
		end
	endtask

	// ==================================================
	// One case with its writes, handshake and checks
	// ==================================================
	task automatic run_case(input int i);
		case_t      c;
		xlat_resp_t held;
		int         n;
		int         errs_before;
		bit         acked;
		c           = cases[i];
		errs_before = errors;
		apply_write(c.wr0);
		apply_write(c.wr1);
		paging_en = c.paging_en;
		pebble_en = c.pebble_en;
		regset    = c.regset;
		xreq      = c.req;
		req       = 1'b1;
		n         = 0;
		acked     = 1'b0;
		while (!acked && n < ACK_WAIT) begin
			@(posedge clk);
			#DRV;
			n++;
			acked = ack;                         // Sampled well after the edge
		end
		if (!acked) begin
			$display("case %s: ack_o never rose within %0d cycles", case_name[i], ACK_WAIT);
			errors++;
		end else begin
			if (n != ACK_LAT) begin
				$display("mismatch %s ack latency: expected %0d, actual %0d",
					case_name[i], ACK_LAT, n);
				errors++;
			end
			if (resp.fault !== c.exp_fault) begin
				$display("mismatch %s fault: expected %s, actual %s", case_name[i],
					fault_name(c.exp_fault), fault_name(resp.fault));
				errors++;
			end
			if (c.exp_fault == FLT_NONE && resp.padr !== c.exp_padr) begin
				$display("mismatch %s padr: expected %h, actual %h", case_name[i],
					c.exp_padr, resp.padr);
				errors++;
			end
			held = resp;
			repeat (c.hold) begin                // Answer must not move under back-pressure
				@(posedge clk);
				#DRV;
				if (ack !== 1'b1) begin
					$display("mismatch %s held ack: expected 1, actual %b", case_name[i], ack);
					errors++;
				end
				if (resp !== held) begin
					$display("mismatch %s held resp: expected %h, actual %h", case_name[i],
						held, resp);
					errors++;
				end
			end
		end
		req = 1'b0;
		n   = 0;
		while (ack === 1'b1 && n < ACK_WAIT) begin
			@(posedge clk);
			#DRV;
			n++;
		end
		if (ack !== 1'b0) begin
			$display("case %s: ack_o did not fall after req_i was dropped", case_name[i]);
			errors++;
		end else if (acked && n != 1) begin
			$display("mismatch %s ack fall: expected 1, actual %0d", case_name[i], n);
			errors++;
		end
		if (errors == errs_before) begin
			n_pass++;
			$display("case %0d %s: ok", i, case_name[i]);
		end else begin
			$display("case %0d %s: bad, %0d errors", i, case_name[i], errors - errs_before);
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		seed      = 83;
		errors    = 0;
		n_pass    = 0;
		rst       = 1'b1;
		req       = 1'b0;
		xreq      = '0;
		paging_en = 1'b0;
		pebble_en = 1'b0;
		regset    = '0;
		wr        = '0;
		fill_cases();
		repeat (RST_CYCLES) @(posedge clk);
		#DRV;
		rst = 1'b0;
		@(posedge clk);
		#DRV;
		if (ack !== 1'b0) begin
			$display("mismatch reset ack_o: expected 0, actual %b", ack);
			errors++;
		end
		if (resp !== '0) begin
			$display("mismatch reset resp_o: expected 0, actual %h", resp);
			errors++;
		end
		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(i);
		end
		$display("%0d cases, %0d passed, %0d failed, %0d errors", NUM_CASES, n_pass,
			NUM_CASES - n_pass, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Each case fits well inside 40 cycles
	initial begin
		#((NUM_CASES * 40 + RST_CYCLES) * CLK_PERIOD);
		$display("watchdog expired before all cases finished");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/mmu_pkg.sv
// Widths are fixed at 32-bit addresses with 8 KiB pages; changing one width means rechecking the rest
`default_nettype none

package mmu_pkg;

	// ==================================================
	// Address layout
	// ==================================================
	localparam int VADR_W     = 32;                           // Virtual and physical address
	localparam int PAGE_OFS_W = 13;                           // 8 KiB pages
	localparam int TLB_IDX_W  = 6;                            // Bits just above the offset
	localparam int TAG_W      = VADR_W - PAGE_OFS_W - TLB_IDX_W;
	localparam int PPN_W      = VADR_W - PAGE_OFS_W;          // Physical page number
	localparam int NUM_TLB    = 1 << TLB_IDX_W;               // 64 direct-mapped entries

	// ==================================================
	// Pebble (segment bound) table
	// ==================================================
	localparam int SEG_SEL_W = 4;                             // Top address bits pick the segment
	localparam int REGSET_W  = 2;                             // Register set number
	localparam int LIMIT_W   = VADR_W - PAGE_OFS_W - SEG_SEL_W; // Pages within a segment
	localparam int BND_IDX_W = REGSET_W + SEG_SEL_W;          // Same width as the write index
	localparam int NUM_BND   = 1 << BND_IDX_W;

	// Requester attributes
	localparam int ASID_W = 8;
	localparam int CPL_W  = 2;                                // 0 is the most privileged

	// Page attributes
	typedef struct packed {
		logic             valid;
		logic             writable;
		logic [CPL_W-1:0] pl;                                 // Lowest privilege allowed
		logic [PPN_W-1:0] ppn;
	} pte_t;

	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [ASID_W-1:0] asid;
		pte_t              pte;
	} tlb_entry_t;

	localparam int TLB_ENT_W = $bits(tlb_entry_t);

	// One translation request held steady during the handshake
	typedef struct packed {
		logic [VADR_W-1:0] vadr;
		logic [ASID_W-1:0] asid;
		logic [CPL_W-1:0]  cpl;
		logic              we;                                // Store access
	} xlat_req_t;

	// One-hot write port opcodes so a stuck or unset target is visible
	typedef enum logic [1:0] {
		WR_TLB   = 2'b01,
		WR_BOUND = 2'b10
	} wr_target_e;

	typedef struct packed {
		logic                 en;                             // One-cycle strobe
		wr_target_e           target;
		logic [TLB_IDX_W-1:0] index;                          // TLB slot or {regset, segment}
		logic [TLB_ENT_W-1:0] data;                           // Bound writes use the low LIMIT_W bits
	} mmu_wr_t;

	// Listed in priority order after FLT_NONE
	typedef enum logic [2:0] {
		FLT_NONE  = 3'd0,
		FLT_BOUND = 3'd1,
		FLT_MISS  = 3'd2,
		FLT_PRIV  = 3'd3,
		FLT_WRITE = 3'd4
	} fault_e;

	typedef struct packed {
		logic [VADR_W-1:0] padr;
		fault_e            fault;
	} xlat_resp_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOK,
		ST_ACK
	} xlat_state_e;

endpackage

`default_nettype wire

// File: verilog/mmu_top.sv
// One data port only; wr_i may be strobed only while req_i and ack_o are both low
`timescale 1ns/1ns
`default_nettype none

module mmu_top import mmu_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                req_i,        // Four-phase request
	input  wire xlat_req_t           xlat_req_i,
	input  wire logic                paging_en_i,
	input  wire logic                pebble_en_i,
	input  wire logic [REGSET_W-1:0] regset_i,     // Pebble register set
	input  wire mmu_wr_t             wr_i,         // TLB or bound write strobe
	output logic                     ack_o,
	output xlat_resp_t               resp_o
);

	tlb_entry_t tlb_entry;    // TLB to combiner
	logic       tlb_hit;
	logic       bound_exc;    // Pebbles to combiner

	// ==================================================
	// Parallel lookups
	// ==================================================
	pebble_bounds pebble_bounds_i (
		.clk         (clk),
		.rst         (rst),
		.vadr_i      (xlat_req_i.vadr),
		.regset_i    (regset_i),
		.wr_i        (wr_i),
		.bound_exc_o (bound_exc)
	);

	tlb_direct tlb_direct_i (
		.clk     (clk),
		.rst     (rst),
		.vadr_i  (xlat_req_i.vadr),
		.asid_i  (xlat_req_i.asid),
		.wr_i    (wr_i),
		.entry_o (tlb_entry),
		.hit_o   (tlb_hit)
	);

	// Merge results and run the handshake
	xlat_combine xlat_combine_i (
		.clk         (clk),
		.rst         (rst),
		.req_i       (req_i),
		.xlat_req_i  (xlat_req_i),
		.paging_en_i (paging_en_i),
		.pebble_en_i (pebble_en_i),
		.entry_i     (tlb_entry),
		.hit_i       (tlb_hit),
		.bound_exc_i (bound_exc),
		.ack_o       (ack_o),
		.resp_o      (resp_o)
	);

endmodule

`default_nettype wire

// File: verilog/pebble_bounds.sv
// Limits only, no base relocation; all limits reset to zero so only page 0 of a segment passes
`timescale 1ns/1ns
`default_nettype none

module pebble_bounds import mmu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [VADR_W-1:0] vadr_i,      // Address under lookup
	input  wire logic [REGSET_W-1:0] regset_i,  // Active register set
	input  wire mmu_wr_t           wr_i,        // Shared write strobe
	output logic                   bound_exc_o  // Page beyond segment limit, one cycle later
);

	// ==================================================
	// Limit storage
	// ==================================================
	logic [LIMIT_W-1:0] limit_q [NUM_BND];      // Indexed by {regset, segment}

	logic [BND_IDX_W-1:0] rd_idx;
	logic [LIMIT_W-1:0]   seg_page;             // Page number inside the segment
	logic                 wr_bnd;

	assign rd_idx   = {regset_i, vadr_i[VADR_W-1 -: SEG_SEL_W]};
	assign seg_page = vadr_i[PAGE_OFS_W +: LIMIT_W];
	assign wr_bnd   = wr_i.en && (wr_i.target == WR_BOUND);

	// Table write, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_BND; i++) begin
				limit_q[i] <= '0;
			end
		end else if (wr_bnd) begin
			limit_q[wr_i.index] <= wr_i.data[LIMIT_W-1:0];   // Only the low bits carry the limit
		end
	end

	// ==================================================
	// Registered compare
	// ==================================================
	// A limit of N allows pages 0..N of the segment
	always_ff @(posedge clk) begin
		if (rst) begin
			bound_exc_o <= 1'b0;
		end else begin
			bound_exc_o <= seg_page > limit_q[rd_idx];
		end
	end

endmodule

`default_nettype wire

// File: verilog/tlb_direct.sv
// Direct-mapped and software loaded; no walker, so a missing entry stays missing until written
`timescale 1ns/1ns
`default_nettype none

module tlb_direct import mmu_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [VADR_W-1:0] vadr_i,     // Address under lookup
	input  wire logic [ASID_W-1:0] asid_i,     // Address space of the request
	input  wire mmu_wr_t           wr_i,       // Shared write strobe
	output tlb_entry_t             entry_o,    // Indexed entry, one cycle later
	output logic                   hit_o       // Valid with tag and ASID match
);

	// ==================================================
	// Entry storage
	// ==================================================
	tlb_entry_t           mem_q [NUM_TLB];     // Tag, ASID and page attributes
	logic [NUM_TLB-1:0]   vld_q;               // Per-entry valid bits

	logic [TLB_IDX_W-1:0] rd_idx;
	logic [TAG_W-1:0]     rd_tag;
	tlb_entry_t           rd_ent;              // Entry with its live valid bit
	tlb_entry_t           wr_ent;
	logic                 wr_tlb;

	assign rd_idx = vadr_i[PAGE_OFS_W +: TLB_IDX_W];  // Bits just above the page offset
	assign rd_tag = vadr_i[VADR_W-1 -: TAG_W];        // Remaining upper bits
	assign wr_ent = wr_i.data;
	assign wr_tlb = wr_i.en && (wr_i.target == WR_TLB);

	// Memory array write
	always_ff @(posedge clk) begin
		if (wr_tlb) begin
			mem_q[wr_i.index] <= wr_ent;
		end
	end

	// Valid vector follows the written entry's valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= '0;
		end else if (wr_tlb) begin
			vld_q[wr_i.index] <= wr_ent.pte.valid;
		end
	end

	// Merge the valid vector into the read entry
	always_comb begin
		rd_ent           = mem_q[rd_idx];
		rd_ent.pte.valid = vld_q[rd_idx];
	end

	// ==================================================
	// Registered lookup
	// ==================================================
	always_ff @(posedge clk) begin
		entry_o <= rd_ent;                     // Payload qualified by hit_o
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= rd_ent.pte.valid
				&& (rd_ent.tag == rd_tag)
				&& (rd_ent.asid == asid_i);    // Entries are private to one ASID
		end
	end

	// Both lookup units decode the same target field
	a_wr_target: assert property (@(posedge clk) disable iff (rst)
		wr_i.en |-> (wr_i.target inside {WR_TLB, WR_BOUND}))
		else $error("write strobe with unknown target %b", wr_i.target);

endmodule

`default_nettype wire

// File: verilog/xlat_combine.sv
// Expects four-phase req/ack with request and mode inputs stable while req_i is high
`timescale 1ns/1ns
`default_nettype none

module xlat_combine import mmu_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       req_i,        // Requester side of the handshake
	input  wire xlat_req_t  xlat_req_i,   // Stable while req_i is high
	input  wire logic       paging_en_i,  // Off means pass-through
	input  wire logic       pebble_en_i,  // Off skips the bound check
	input  wire tlb_entry_t entry_i,      // Registered TLB entry
	input  wire logic       hit_i,        // Registered TLB hit
	input  wire logic       bound_exc_i,  // Registered segment overflow
	output logic            ack_o,        // MMU side of the handshake
	output xlat_resp_t      resp_o        // Held while ack_o is high
);

	xlat_state_e state_q;

	logic [VADR_W-1:0]     padr_c;
	logic [PAGE_OFS_W-1:0] ofs;
	fault_e                fault_c;

	assign ofs = xlat_req_i.vadr[PAGE_OFS_W-1:0];

	// ==================================================
	// Address and fault selection
	// ==================================================
	always_comb begin
		if (paging_en_i) begin
			padr_c = {entry_i.pte.ppn, ofs};   // Page frame plus offset
		end else begin
			padr_c = xlat_req_i.vadr;          // Untranslated
		end
	end

	// Highest priority fault wins
	always_comb begin
		fault_c = FLT_NONE;
		if (pebble_en_i && bound_exc_i) begin
			fault_c = FLT_BOUND;
		end else if (paging_en_i) begin
			if (!hit_i) begin
				fault_c = FLT_MISS;            // No walker, reported only
			end else if (xlat_req_i.cpl > entry_i.pte.pl) begin
				fault_c = FLT_PRIV;            // Larger cpl is less privileged
			end else if (xlat_req_i.we && !entry_i.pte.writable) begin
				fault_c = FLT_WRITE;
			end
		end
	end

	// ==================================================
	// Handshake FSM
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			ack_o   <= 1'b0;
			resp_o  <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (req_i) begin
						state_q <= ST_LOOK;    // Lookup units sample this same edge
					end
				end
				ST_LOOK: begin
					resp_o.padr  <= padr_c;
					resp_o.fault <= fault_c;
					ack_o        <= 1'b1;
					state_q      <= ST_ACK;
				end
				ST_ACK: begin
					// Hold the answer until the requester lets go
					if (!req_i) begin
						ack_o   <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: begin
					ack_o   <= 1'b0;
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Idle means the previous handshake has fully closed
	a_idle_no_ack: assert property (@(posedge clk) disable iff (rst)
		(state_q == ST_IDLE) |-> !ack_o)
		else $error("ack_o high while idle");

	// Requester must wait for ack before dropping req
	a_look_req_held: assert property (@(posedge clk) disable iff (rst)
		(state_q == ST_LOOK) |-> req_i)
		else $error("req_i dropped before ack_o");

endmodule

`default_nettype wire
